/* all.f */
hdl/mode_pkg.sv
hdl/media_pkg.sv
hdl/key_debounce.sv
hdl/mode_ctrl.sv
hdl/led_pattern.sv
hdl/output_select.sv
hdl/demo_top.sv
testbench/tb_demo_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_demo_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_demo_top.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_demo_top
	import mode_pkg::*;
	import media_pkg::*;
();

	localparam int DEB_CYCLES     = 8;
	localparam int BLINK_W        = 8;
	localparam int SDRAM_RST      = 16;
	localparam int HOLD_CYCLES    = DEB_CYCLES + 4;
	localparam int NUM_ROWS       = 8;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 64 + 200;

	// one step of the mode table
	typedef struct packed {
		logic [1:0] key;       // 0 key2, 1 key3, 2 key4
		mode_t      mode;
		logic       buzzer_en;
		logic       cam_en;
		logic       sd_en;
		logic [1:0] seg_src;   // 0 rtc, 1 eeprom, 2 sd
		logic [1:0] video_src; // 0 bar, 1 cam, 2 sd
		logic       burst_src; // 0 cam, 1 sd
		logic       rst_pulse; // sdram reset expected
	} row_t;

	logic       clk;
	logic       rst_n;
	logic [2:0] keys_n; // active low keys with key2 in bit 0
	logic [3:0] led;
	logic       buzzer_en, cam_en, sd_en, sdram_rst_n;
	seg_t       rtc_seg, eeprom_seg, sd_seg, seg;
	video_t     bar_video, cam_video, sd_video, video;
	burst_req_t cam_burst, sd_burst, burst;

	row_t        rows [NUM_ROWS];
	logic [31:0] lfsr_q = 32'hda5e_8bed;
	int          cycle_cnt;
	int          blink_steps; // posedges since reset release
	int          low_run, pulse_len;
	logic        saw_low;
	int          test_errors, err_cnt, pass_cnt, fail_cnt;

	demo_top #(
		.DEBOUNCE_CYCLES (DEB_CYCLES),
		.BLINK_WIDTH     (BLINK_W)
	) i_dut (
		.clk (clk), .rst_n (rst_n),
		.key2 (keys_n[0]), .key3 (keys_n[1]), .key4 (keys_n[2]),
		.led (led), .buzzer_en (buzzer_en), .cam_en (cam_en), .sd_en (sd_en),
		.sdram_rst_n (sdram_rst_n),
		.rtc_seg (rtc_seg), .eeprom_seg (eeprom_seg), .sd_seg (sd_seg), .seg (seg),
		.bar_video (bar_video), .cam_video (cam_video), .sd_video (sd_video),
		.video (video),
		.cam_burst (cam_burst), .sd_burst (sd_burst), .burst (burst)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [127:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[126:0], lfsr_q[0]};
		end
	endtask

	// distinct values per source so the selected one is identifiable
	task automatic fill_sources();
		logic [127:0] v;
		draw_bits($bits(seg_t), v);
		rtc_seg = v[$bits(seg_t)-1:0];
		do
			draw_bits($bits(seg_t), v);
		while (v[$bits(seg_t)-1:0] == rtc_seg);
		eeprom_seg = v[$bits(seg_t)-1:0];
		do
			draw_bits($bits(seg_t), v);
		while (v[$bits(seg_t)-1:0] == rtc_seg || v[$bits(seg_t)-1:0] == eeprom_seg);
		sd_seg = v[$bits(seg_t)-1:0];
		draw_bits($bits(video_t), v);
		bar_video = v[$bits(video_t)-1:0];
		do
			draw_bits($bits(video_t), v);
		while (v[$bits(video_t)-1:0] == bar_video);
		cam_video = v[$bits(video_t)-1:0];
		do
			draw_bits($bits(video_t), v);
		while (v[$bits(video_t)-1:0] == bar_video || v[$bits(video_t)-1:0] == cam_video);
		sd_video = v[$bits(video_t)-1:0];
		draw_bits($bits(burst_req_t), v);
		cam_burst = v[$bits(burst_req_t)-1:0];
		do
			draw_bits($bits(burst_req_t), v);
		while (v[$bits(burst_req_t)-1:0] == cam_burst);
		sd_burst = v[$bits(burst_req_t)-1:0];
	endtask

	// led lags the blink counter by one edge
	function automatic logic [3:0] expected_led(input mode_t m, input int steps);
		logic [BLINK_W-1:0] c;
		logic [3:0]         e;
		c = BLINK_W'(steps - 1);
		e = '0;
		case (m)
			mode_ledflash: e[c[BLINK_W-1:BLINK_W-2]] = 1'b1; // walk position from the top two bits
			mode_eeprom:   e[0] = c[BLINK_W-1];
			mode_sd:       e[1:0] = {2{c[BLINK_W-1]}};
			default:       e = {4{c[BLINK_W-3]}};
		endcase
		return e;
	endfunction

	// advance to the next falling edge and measure the sdram reset pulse
	task automatic tick();
		@(negedge clk);
		blink_steps++;
		if (!sdram_rst_n)
		begin
			low_run++;
			saw_low = 1'b1;
		end
		else if (low_run != 0)
		begin
			pulse_len = low_run;
			low_run   = 0;
		end
	endtask

	task automatic press_key(input logic [1:0] k);
		keys_n[k] = 1'b0;
		repeat (HOLD_CYCLES) tick();
		keys_n[k] = 1'b1;
		repeat (HOLD_CYCLES) tick();
	endtask

	task automatic check_eq(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERROR %s: expected %0h, got %0h", name, exp, got);
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0)
		begin
			pass_cnt++;
			$display("%-16s ok", name);
		end
		else
		begin
			fail_cnt++;
			$display("%-16s failed with %0d errors", name, test_errors);
		end
		err_cnt    += test_errors;
		test_errors = 0;
	endtask

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout, no result after %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		row_t       r;
		seg_t       exp_seg;
		video_t     exp_video;
		burst_req_t exp_burst;
		rows[0] = '{2'd0, mode_ledflash, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 1'b0, 1'b0};
		rows[1] = '{2'd0, mode_ledflash, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 1'b0, 1'b0}; // repeat
		rows[2] = '{2'd1, mode_eeprom,   1'b0, 1'b1, 1'b0, 2'd1, 2'd1, 1'b0, 1'b0};
		rows[3] = '{2'd2, mode_sd,       1'b0, 1'b0, 1'b1, 2'd2, 2'd2, 1'b1, 1'b1};
		rows[4] = '{2'd2, mode_sd,       1'b0, 1'b0, 1'b1, 2'd2, 2'd2, 1'b1, 1'b0}; // repeat
		rows[5] = '{2'd0, mode_ledflash, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 1'b0, 1'b1};
		rows[6] = '{2'd1, mode_eeprom,   1'b0, 1'b1, 1'b0, 2'd1, 2'd1, 1'b0, 1'b0};
		rows[7] = '{2'd0, mode_ledflash, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 1'b0, 1'b0};
		{test_errors, err_cnt, pass_cnt, fail_cnt} = '0;
		{low_run, pulse_len, blink_steps} = '0;
		saw_low = 1'b0;
		rst_n   = 1'b0;
		keys_n  = 3'b111;
		fill_sources();

		repeat (16) @(negedge clk);
		check_eq("led", led, 4'b0000);
		check_eq("buzzer_en", buzzer_en, 1'b0);
		check_eq("cam_en", cam_en, 1'b0);
		check_eq("sd_en", sd_en, 1'b0);
		check_eq("sdram_rst_n", sdram_rst_n, 1'b0);
		check_eq("seg", seg, '0);
		check_eq("video", video, '0);
		check_eq("burst", burst, '0);
		report_test("in reset");

		rst_n = 1'b1;
		tick();
		tick();
		check_eq("sdram_rst_n", sdram_rst_n, 1'b1); // released once idle
		check_eq("cam_en", cam_en, 1'b1);
		check_eq("buzzer_en", buzzer_en, 1'b0);
		check_eq("sd_en", sd_en, 1'b0);
		check_eq("led", led, expected_led(mode_idle, blink_steps));
		check_eq("video", video, bar_video);
		report_test("after reset");

		for (int i = 0; i < NUM_ROWS; i++)
		begin
			r         = rows[i];
			saw_low   = 1'b0;
			pulse_len = 0;
			fill_sources();
			press_key(r.key);
			while (!sdram_rst_n)
				tick(); // let a running sdram reset finish
			exp_seg   = (r.seg_src == 2'd0) ? rtc_seg :
				(r.seg_src == 2'd1) ? eeprom_seg : sd_seg;
			exp_video = (r.video_src == 2'd0) ? bar_video :
				(r.video_src == 2'd1) ? cam_video : sd_video;
			exp_burst = r.burst_src ? sd_burst : cam_burst;
			check_eq("mode", i_dut.mode, r.mode);
			check_eq("buzzer_en", buzzer_en, r.buzzer_en);
			check_eq("cam_en", cam_en, r.cam_en);
			check_eq("sd_en", sd_en, r.sd_en);
			check_eq("seg", seg, exp_seg);
			check_eq("video", video, exp_video);
			check_eq("burst", burst, exp_burst);
			check_eq("led", led, expected_led(r.mode, blink_steps));
			if (r.mode == mode_ledflash)
			begin
				assert ($onehot(led))
				else
				begin
					$display("led is not one-hot in led-flash mode: %b", led);
					test_errors++;
				end
			end
			if (r.rst_pulse)
				check_eq("sdram_rst_n low cycles", pulse_len, SDRAM_RST);
			else
			begin
				assert (!saw_low)
				else
				begin
					$display("sdram_rst_n went low on a move that does not touch sd mode");
					test_errors++;
				end
			end
			report_test($sformatf("row %0d key%0d", i, r.key + 2));
		end

		$display("%0d of %0d tests passed, %0d errors", pass_cnt, pass_cnt + fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/demo_top.sv */
`default_nettype none
`timescale 1ns/1ns

module demo_top
	import mode_pkg::*;
	import media_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES  = 500000,
	parameter int BLINK_WIDTH      = 25,    // at least 3
	parameter int SDRAM_RST_CYCLES = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       key2,
	input  logic       key3,
	input  logic       key4,
	output logic [3:0] led,
	output logic       buzzer_en,
	output logic       cam_en,
	output logic       sd_en,
	output logic       sdram_rst_n,
	input  seg_t       rtc_seg,
	input  seg_t       eeprom_seg,
	input  seg_t       sd_seg,
	output seg_t       seg,
	input  video_t     bar_video,
	input  video_t     cam_video,
	input  video_t     sd_video,
	output video_t     video,
	input  burst_req_t cam_burst,
	input  burst_req_t sd_burst,
	output burst_req_t burst
);

	wire key_press_t keys;
	wire mode_t      mode;

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_k2 (
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key2),
		.press (keys.k2)
	);

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_k3 (
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key3),
		.press (keys.k3)
	);

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_k4 (
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key4),
		.press (keys.k4)
	);

	mode_ctrl #(.SDRAM_RST_CYCLES(SDRAM_RST_CYCLES)) i_mode_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.keys        (keys),
		.mode        (mode),
		.buzzer_en   (buzzer_en),
		.cam_en      (cam_en),
		.sd_en       (sd_en),
		.sdram_rst_n (sdram_rst_n)
	);

	led_pattern #(.BLINK_WIDTH(BLINK_WIDTH)) i_led_pattern (
		.clk   (clk),
		.rst_n (rst_n),
		.mode  (mode),
		.led   (led)
	);

	output_select i_output_select (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.rtc_seg    (rtc_seg),
		.eeprom_seg (eeprom_seg),
		.sd_seg     (sd_seg),
		.seg        (seg),
		.bar_video  (bar_video),
		.cam_video  (cam_video),
		.sd_video   (sd_video),
		.video      (video),
		.cam_burst  (cam_burst),
		.sd_burst   (sd_burst),
		.burst      (burst)
	);

endmodule

`default_nettype wire

/* hdl/output_select.sv */
`default_nettype none
`timescale 1ns/1ns

module output_select
	import mode_pkg::*;
	import media_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mode_t      mode,
	input  seg_t       rtc_seg,
	input  seg_t       eeprom_seg,
	input  seg_t       sd_seg,
	output seg_t       seg,
	input  video_t     bar_video,
	input  video_t     cam_video,
	input  video_t     sd_video,
	output video_t     video,
	input  burst_req_t cam_burst,
	input  burst_req_t sd_burst,
	output burst_req_t burst
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seg   <= '0;
			video <= '0;
			burst <= '0;
		end
		else
		begin
			case (mode)
				mode_idle:
				begin
					seg   <= rtc_seg;
					video <= bar_video; // test pattern while idle
					burst <= cam_burst;
				end
				mode_ledflash:
				begin
					seg   <= rtc_seg;
					video <= cam_video;
					burst <= cam_burst;
				end
				mode_eeprom:
				begin
					seg   <= eeprom_seg;
					video <= cam_video;
					burst <= cam_burst;
				end
				mode_sd:
				begin
					// sd picture path owns display, video and sdram
					seg   <= sd_seg;
					video <= sd_video;
					burst <= sd_burst;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/led_pattern.sv */
`default_nettype none
`timescale 1ns/1ns

module led_pattern
	import mode_pkg::*;
#(
	parameter int BLINK_WIDTH = 25
) (
	input  logic       clk,
	input  logic       rst_n,
	input  mode_t      mode,
	output logic [3:0] led
);

	logic [BLINK_WIDTH-1:0] blink_cnt;
	logic                   b1; // slowest blink
	logic                   b3; // four times faster

	assign b1 = blink_cnt[BLINK_WIDTH-1];
	assign b3 = blink_cnt[BLINK_WIDTH-3];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			blink_cnt <= '0;
		else
			blink_cnt <= blink_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			led <= 4'b0000;
		else
		begin
			case (mode)
				mode_ledflash: led <= 4'b0001 << blink_cnt[BLINK_WIDTH-1 -: 2]; // walking light
				mode_eeprom:   led <= {3'b000, b1};
				mode_sd:       led <= {2'b00, b1, b1};
				default:       led <= {4{b3}}; // idle, all together
			endcase
		end
	end

	a_walk_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		mode == mode_ledflash |=> $onehot(led));

endmodule

`default_nettype wire

/* hdl/mode_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns

module mode_ctrl
	import mode_pkg::*;
#(
	parameter int SDRAM_RST_CYCLES = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	input  key_press_t keys,
	output mode_t      mode,
	output logic       buzzer_en,
	output logic       cam_en,
	output logic       sd_en,
	output logic       sdram_rst_n
);

	localparam int RST_W = $clog2(SDRAM_RST_CYCLES + 1);
	localparam logic [RST_W-1:0] RST_LAST = RST_W'(SDRAM_RST_CYCLES - 1);

	mode_t            next_mode;
	logic [RST_W-1:0] rst_cnt_q;
	logic             sd_switch; // press that enters or leaves sd mode

	// k2 over k3 over k4, and the key of the current mode does nothing
	always_comb
	begin
		next_mode = mode;
		if (keys.k2 && mode != mode_ledflash)
			next_mode = mode_ledflash;
		else if (keys.k3 && mode != mode_eeprom)
			next_mode = mode_eeprom;
		else if (keys.k4 && mode != mode_sd)
			next_mode = mode_sd;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mode <= mode_idle;
		else
			mode <= next_mode;
	end

	// subsystem run enables, one cycle behind mode
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			buzzer_en <= 1'b0;
			sd_en     <= 1'b0;
			cam_en    <= 1'b0;
		end
		else
		begin
			buzzer_en <= (mode == mode_ledflash);
			sd_en     <= (mode == mode_sd);
			cam_en    <= (mode != mode_sd); // camera and sd share the sdram
		end
	end

	assign sd_switch = (mode == mode_sd) ? (keys.k2 | keys.k3) : keys.k4;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sdram_rst_n <= 1'b0;
		else if (sd_switch)
			sdram_rst_n <= 1'b0;
		else if (rst_cnt_q == RST_LAST || mode == mode_idle)
			sdram_rst_n <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rst_cnt_q <= '0;
		else if (sdram_rst_n)
			rst_cnt_q <= '0;
		else
			rst_cnt_q <= rst_cnt_q + 1'b1; // length of the low pulse
	end

	a_sd_cam_excl: assert property (@(posedge clk) disable iff (!rst_n) !(sd_en && cam_en));

endmodule

`default_nettype wire

/* hdl/key_debounce.sv */
`default_nettype none
`timescale 1ns/1ns

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic key,   // active low, asynchronous
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [1:0]       sync_q;  // [1] is the synchronized key
	logic             level_q; // debounced level, high = released
	logic [CNT_W-1:0] cnt_q;
	logic             settle;

	// new level has held long enough
	assign settle = (sync_q[1] != level_q) && (cnt_q == CNT_LAST);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], key};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt_q   <= '0;
			level_q <= 1'b1;
		end
		else if (sync_q[1] == level_q)
			cnt_q <= '0; // bounce back, start over
		else if (settle)
		begin
			cnt_q   <= '0;
			level_q <= sync_q[1];
		end
		else
			cnt_q <= cnt_q + 1'b1;
	end

	// strobe on the falling debounced level only
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			press <= 1'b0;
		else
			press <= settle && !sync_q[1];
	end

	a_press_single: assert property (@(posedge clk) disable iff (!rst_n) press |=> !press);

endmodule

`default_nettype wire

/* hdl/media_pkg.sv */
`default_nettype none

package media_pkg;

	localparam int BURST_LEN_W  = 10;
	localparam int BURST_ADDR_W = 24;
	localparam int BURST_DATA_W = 16;

	// six digit seven-segment display
	typedef struct packed {
		logic [5:0] sel;  // digit select
		logic [7:0] data; // segments incl. dp
	} seg_t;

	// 565 rgb video with syncs
	typedef struct packed {
		logic       hs;
		logic       vs;
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} video_t;

	// request side of the sdram burst port
	typedef struct packed {
		logic                    rd_req;
		logic                    wr_req;
		logic [BURST_LEN_W-1:0]  rd_len;
		logic [BURST_LEN_W-1:0]  wr_len;
		logic [BURST_ADDR_W-1:0] rd_addr;
		logic [BURST_ADDR_W-1:0] wr_addr;
		logic [BURST_DATA_W-1:0] wr_data;
	} burst_req_t;

endpackage

`default_nettype wire

/* hdl/mode_pkg.sv */
`default_nettype none

package mode_pkg;

	// board operating modes, stepped by the three keys
	typedef enum logic [1:0] {
		mode_idle     = 2'd0,
		mode_ledflash = 2'd1,
		mode_eeprom   = 2'd2,
		mode_sd       = 2'd3
	} mode_t;

	// one-cycle press strobes from the debouncers
	typedef struct packed {
		logic k2; // led-flash key
		logic k3; // eeprom key
		logic k4; // sd key
	} key_press_t;

endpackage

`default_nettype wire
